// File: burstCounter.sv
`timescale 1ns/1ps

module burstCounter
  import cachePkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   beatInc,
  input  logic   beatClear,
  input  logic   setInc,
  input  logic   setClear,
  output offsetT beat,
  output logic   lastBeat,
  output setT    flushSet,
  output logic   lastSet
);

  // Word position within the current burst
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      beat <= '0;
    end else if (beatClear) begin
      beat <= '0;
    end else if (beatInc) begin
      beat <= beat + offsetT'(1);
    end
  end

  // Set walked by a flush
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flushSet <= '0;
    end else if (setClear) begin
      flushSet <= '0;
    end else if (setInc) begin
      flushSet <= flushSet + setT'(1);
    end
  end

  assign lastBeat = (beat == offsetT'(wordsPerBlock - 1));
  assign lastSet  = (flushSet == setT'(numSets - 1));

endmodule

// File: cacheController.sv
`timescale 1ns/1ps

module cacheController
  import cachePkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic reqValid,
  input  logic reqWrite,
  input  logic flushValid,
  input  logic busReady,
  input  logic hit,
  input  logic victimDirty,
  input  logic dirtyW0,
  input  logic dirtyW1,
  input  logic lastBeat,
  input  logic lastSet,
  output logic reqReady,
  output logic flushReady,
  output logic busValid,
  output logic busWrite,
  output logic beatInc,
  output logic beatClear,
  output logic setInc,
  output logic setClear,
  output logic fillWe,
  output logic wordWe,
  output logic tagWe,
  output logic makeDirty,
  output logic cleanWay,
  output logic flushWay,
  output logic touchLru,
  output logic useFlushSet
);

  ctrlStateT state;
  ctrlStateT nextState;

  logic flushValidQ;
  logic flushStart;
  logic anyDirty;

  assign flushStart = flushValid & ~flushValidQ;
  assign anyDirty   = dirtyW0 | dirtyW1;

  // Way 0 is written back first when both are dirty
  assign flushWay = ~dirtyW0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= idle;
      flushValidQ <= 1'b0;
      flushReady  <= 1'b0;
    end else begin
      state       <= nextState;
      flushValidQ <= flushValid;
      // Done pulse lands in the first idle cycle after the walk
      flushReady  <= (state == flushScan) && !anyDirty && lastSet;
    end
  end

  always_comb begin
    nextState   = state;
    reqReady    = 1'b0;
    busValid    = 1'b0;
    busWrite    = 1'b0;
    beatInc     = 1'b0;
    beatClear   = 1'b0;
    setInc      = 1'b0;
    setClear    = 1'b0;
    fillWe      = 1'b0;
    wordWe      = 1'b0;
    tagWe       = 1'b0;
    makeDirty   = 1'b0;
    cleanWay    = 1'b0;
    touchLru    = 1'b0;
    useFlushSet = 1'b0;

    case (state)
      idle: begin
        beatClear = 1'b1;
        setClear  = 1'b1;
        if (reqValid) begin
          if (hit) begin
            reqReady  = 1'b1;
            touchLru  = 1'b1;
            wordWe    = reqWrite;
            makeDirty = reqWrite;
          end else if (victimDirty) begin
            nextState = writeBack;
          end else begin
            nextState = memRead;
          end
        end else if (flushStart) begin
          nextState = flushScan;
        end
      end

      writeBack: begin
        busValid = 1'b1;
        busWrite = 1'b1;
        beatInc  = busReady;
        if (busReady && lastBeat) begin
          nextState = memRead;
        end
      end

      memRead: begin
        busValid = 1'b1;
        beatInc  = busReady;
        fillWe   = busReady;
        // Tag goes in with the last word so the retry hits
        if (busReady && lastBeat) begin
          tagWe     = 1'b1;
          nextState = idle;
        end
      end

      flushScan: begin
        useFlushSet = 1'b1;
        beatClear   = 1'b1;
        if (anyDirty) begin
          nextState = flushWrite;
        end else if (lastSet) begin
          nextState = idle;
        end else begin
          setInc = 1'b1;
        end
      end

      flushWrite: begin
        useFlushSet = 1'b1;
        busValid    = 1'b1;
        busWrite    = 1'b1;
        beatInc     = busReady;
        // Back to scan, the other way of this set may still be dirty
        if (busReady && lastBeat) begin
          cleanWay  = 1'b1;
          nextState = flushScan;
        end
      end

      default: nextState = idle;
    endcase
  end

  // A stalled beat keeps the burst going in the same state
  assert property (@(posedge clk) disable iff (reset)
    (busValid && !busReady) |=> (busValid && (state == $past(state))));

  // Flush done lasts a single cycle
  assert property (@(posedge clk) disable iff (reset)
    flushReady |=> !flushReady);

endmodule

// File: cachePkg.sv
package cachePkg;

  // Cache geometry
  localparam int numSets       = 16;
  localparam int wordsPerBlock = 4;
  localparam int setBits       = 4;
  localparam int offsetBits    = 2;

  // Byte offset inside a 32-bit word
  localparam int byteBits      = 2;

  // Whatever is left of the address above set and word fields
  localparam int tagBits       = 32 - setBits - offsetBits - byteBits;

  // Meaningful widths
  typedef logic [31:0]            addrT;
  typedef logic [31:0]            wordT;
  typedef logic [3:0]             byteMaskT;
  typedef logic [tagBits-1:0]     tagT;
  typedef logic [setBits-1:0]     setT;
  typedef logic [offsetBits-1:0]  offsetT;

  // Controller states
  typedef enum logic [2:0] {
    // Lookup, hits served here
    idle,
    // Dirty victim going out
    writeBack,
    // Refill burst
    memRead,
    // Check one set for dirty ways
    flushScan,
    // Burst of a dirty way during flush
    flushWrite
  } ctrlStateT;

endpackage

// File: cacheTb.sv
`timescale 1ns/1ps

module cacheTb
  import cachePkg::*;
;

  localparam int clkPeriod    = 10;
  localparam int memWords     = 1024;
  localparam int numRounds    = 4;
  localparam int reqPerRound  = 500;
  localparam int seedValue    = 80471;
  // Generous per-request budget plus a worst case walk with every way dirty
  localparam int watchdogCycles = numRounds * reqPerRound * 20
                                + numRounds * numSets * (2 * wordsPerBlock * 20 + 3) + 100;

  logic     clk;
  logic     reset;
  logic     reqValid;
  logic     reqWrite;
  addrT     reqAddr;
  wordT     reqWData;
  byteMaskT reqByteMask;
  logic     reqReady;
  wordT     respRData;
  logic     flushValid;
  logic     flushReady;
  logic     busValid;
  logic     busWrite;
  addrT     busAddr;
  wordT     busWData;
  logic     busReady;
  wordT     busRData;

  integer seed = seedValue;
  integer stallSeed = seedValue + 1;
  int errorCount;
  int checkCount;
  int testCount;

  wordT busMem [memWords];
  wordT refMem [memWords];

  // Residency model, indexed as [way][set]
  tagT  mTag [2][numSets];
  logic mValid [2][numSets];
  logic mDirty [2][numSets];
  logic mLru [numSets];

  // Beats seen on the bus and beats expected for the current operation
  addrT beatAddrQ[$];
  logic beatWriteQ[$];
  wordT beatDataQ[$];
  addrT expAddrQ[$];
  logic expWriteQ[$];
  wordT expDataQ[$];

  dataCache dut0 (
    .clk(clk), .reset(reset), .reqValid(reqValid), .reqWrite(reqWrite),
    .reqAddr(reqAddr), .reqWData(reqWData), .reqByteMask(reqByteMask),
    .reqReady(reqReady), .respRData(respRData), .flushValid(flushValid),
    .flushReady(flushReady), .busValid(busValid), .busWrite(busWrite),
    .busAddr(busAddr), .busWData(busWData), .busReady(busReady), .busRData(busRData)
  );

  function automatic wordT fillPattern(input int idx);
    return (wordT'(idx) * 32'h9E3779B1) ^ 32'h3C6EF372 ^ wordT'(idx);
  endfunction

  function automatic wordT mergeBytes(input wordT oldWord, input wordT newWord,
                                      input byteMaskT mask);
    wordT result;
    result = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        result[b*8 +: 8] = newWord[b*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkAddr(input string name, input addrT got, input addrT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // One block burst in word order, write data taken from the reference
  task automatic addBurst(input logic write, input tagT tag, input setT s);
    addrT a;
    for (int k = 0; k < wordsPerBlock; k++) begin
      a = {tag, s, offsetT'(k), 2'b00};
      expAddrQ.push_back(a);
      expWriteQ.push_back(write);
      expDataQ.push_back(refMem[a[11:2]]);
    end
  endtask

  task automatic checkBeats(input int startIdx);
    int n;
    n = beatAddrQ.size() - startIdx;
    checkCount++;
    if (n != expAddrQ.size()) begin
      errorCount++;
      $display("bus carried %0d beats where %0d were expected", n, expAddrQ.size());
    end
    for (int k = 0; k < n && k < expAddrQ.size(); k++) begin
      checkAddr("busAddr", beatAddrQ[startIdx + k], expAddrQ[k]);
      checkFlag("busWrite", beatWriteQ[startIdx + k], expWriteQ[k]);
      if (expWriteQ[k]) begin
        checkWord("busWData", beatDataQ[startIdx + k], expDataQ[k]);
      end
    end
  endtask

  task automatic randomRequest();
    wordT     r;
    wordT     wdata;
    wordT     got;
    tagT      tag;
    setT      s;
    offsetT   off;
    addrT     addr;
    byteMaskT mask;
    logic     write;
    logic     hitM;
    logic     way;
    int       startIdx;
    r = $random(seed);
    wdata = $random(seed);
    // Mostly two hot tags per set, sometimes any of sixteen
    tag   = (r[1:0] != 2'b00) ? tagT'(r[10]) : tagT'(r[13:10]);
    s     = r[7:4];
    off   = r[15:14];
    write = r[16];
    mask  = r[20:17];
    addr  = {tag, s, off, 2'b00};
    hitM  = 1'b0;
    way   = 1'b0;
    expAddrQ.delete();
    expWriteQ.delete();
    expDataQ.delete();
    for (int w = 0; w < 2; w++) begin
      if (mValid[w][s] && mTag[w][s] == tag) begin
        hitM = 1'b1;
        way  = w[0];
      end
    end
    if (!hitM) begin
      way = !mValid[0][s] ? 1'b0 : (!mValid[1][s] ? 1'b1 : mLru[s]);
      if (mDirty[way][s]) begin
        addBurst(1'b1, mTag[way][s], s);
      end
      addBurst(1'b0, tag, s);
      mTag[way][s]   = tag;
      mValid[way][s] = 1'b1;
      mDirty[way][s] = 1'b0;
    end
    mLru[s] = ~way;
    if (write) begin
      mDirty[way][s] = 1'b1;
    end
    startIdx    = beatAddrQ.size();
    reqValid    = 1'b1;
    reqWrite    = write;
    reqAddr     = addr;
    reqWData    = wdata;
    reqByteMask = mask;
    do begin
      @(posedge clk);
    end while (reqReady !== 1'b1);
    got = respRData;
    @(negedge clk);
    reqValid = 1'b0;
    checkBeats(startIdx);
    if (write) begin
      refMem[addr[11:2]] = mergeBytes(refMem[addr[11:2]], wdata, mask);
    end else begin
      checkWord("respRData", got, refMem[addr[11:2]]);
    end
  endtask

  task automatic flushAll();
    int startIdx;
    expAddrQ.delete();
    expWriteQ.delete();
    expDataQ.delete();
    for (int s = 0; s < numSets; s++) begin
      for (int w = 0; w < 2; w++) begin
        if (mDirty[w][s]) begin
          addBurst(1'b1, mTag[w][s], setT'(s));
          mDirty[w][s] = 1'b0;
        end
      end
    end
    @(negedge clk);
    startIdx   = beatAddrQ.size();
    flushValid = 1'b1;
    do begin
      @(posedge clk);
    end while (flushReady !== 1'b1);
    @(negedge clk);
    flushValid = 1'b0;
    // Done is a single-cycle pulse
    checkFlag("flushReady", flushReady, 1'b0);
    checkBeats(startIdx);
    for (int i = 0; i < memWords; i++) begin
      checkWord("busMem", busMem[i], refMem[i]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Random bus back-pressure, ready about 70 percent of cycles
  initial begin
    wordT stall;
    busReady = 1'b0;
    forever begin
      @(negedge clk);
      stall = $random(stallSeed);
      busReady = (stall[6:0] < 7'd90);
    end
  end

  // Bus memory answers beats and logs them
  initial begin
    for (int i = 0; i < memWords; i++) begin
      busMem[i] <= fillPattern(i);
    end
    forever begin
      @(posedge clk);
      if (busValid && busReady) begin
        beatAddrQ.push_back(busAddr);
        beatWriteQ.push_back(busWrite);
        beatDataQ.push_back(busWData);
        if (busWrite) begin
          busMem[busAddr[11:2]] <= busWData;
        end
      end
    end
  end

  assign busRData = busMem[busAddr[11:2]];

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("timeout: the cache stopped answering before all tests ended");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int errBefore;
    reset       = 1'b1;
    reqValid    = 1'b0;
    reqWrite    = 1'b0;
    reqAddr     = '0;
    reqWData    = '0;
    reqByteMask = '0;
    flushValid  = 1'b0;
    errorCount  = 0;
    checkCount  = 0;
    testCount   = 0;
    for (int i = 0; i < memWords; i++) begin
      refMem[i] = fillPattern(i);
    end
    for (int s = 0; s < numSets; s++) begin
      mLru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        mTag[w][s]   = '0;
        mValid[w][s] = 1'b0;
        mDirty[w][s] = 1'b0;
      end
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int round = 0; round < numRounds; round++) begin
      errBefore = errorCount;
      repeat (reqPerRound) randomRequest();
      testCount++;
      $display("test requests %0d: %0d errors", round, errorCount - errBefore);
      errBefore = errorCount;
      flushAll();
      testCount++;
      $display("test flush %0d: %0d errors", round, errorCount - errBefore);
    end
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: dataCache.sv
`timescale 1ns/1ps

module dataCache
  import cachePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     reqValid,
  input  logic     reqWrite,
  input  addrT     reqAddr,
  input  wordT     reqWData,
  input  byteMaskT reqByteMask,
  output logic     reqReady,
  output wordT     respRData,
  input  logic     flushValid,
  output logic     flushReady,
  output logic     busValid,
  output logic     busWrite,
  output addrT     busAddr,
  output wordT     busWData,
  input  logic     busReady,
  input  wordT     busRData
);

  logic   beatInc, beatClear, setInc, setClear;
  logic   fillWe, wordWe, tagWe, makeDirty, cleanWay, flushWay;
  logic   touchLru, useFlushSet;
  logic   hit, hitWay, victimWay, victimDirty, dirtyW0, dirtyW1;
  logic   lastBeat, lastSet;
  tagT    victimTag;
  offsetT beat;
  setT    flushSet;

  // Request address fields
  tagT    reqTag;
  setT    reqSet;
  offsetT reqOffset;

  tagT    busTag;
  setT    activeSet;
  offsetT activeWord;
  logic   activeWay;
  wordT   rData;

  assign reqOffset = reqAddr[byteBits +: offsetBits];
  assign reqSet    = reqAddr[byteBits + offsetBits +: setBits];
  assign reqTag    = reqAddr[31 -: tagBits];

  assign activeSet  = useFlushSet ? flushSet : reqSet;
  // Bursts walk the block, lookups use the request word
  assign activeWord = busValid ? beat : reqOffset;
  assign activeWay  = useFlushSet ? flushWay : (busValid ? victimWay : hitWay);

  // Writes carry the victim tag, refills the requested one
  assign busTag  = busWrite ? victimTag : reqTag;
  assign busAddr = {busTag, activeSet, beat, {byteBits{1'b0}}};

  assign busWData  = rData;
  assign respRData = rData;

  cacheController ctrl0 (
    .clk(clk), .reset(reset), .reqValid(reqValid), .reqWrite(reqWrite),
    .flushValid(flushValid), .busReady(busReady), .hit(hit),
    .victimDirty(victimDirty), .dirtyW0(dirtyW0), .dirtyW1(dirtyW1),
    .lastBeat(lastBeat), .lastSet(lastSet), .reqReady(reqReady),
    .flushReady(flushReady), .busValid(busValid), .busWrite(busWrite),
    .beatInc(beatInc), .beatClear(beatClear), .setInc(setInc),
    .setClear(setClear), .fillWe(fillWe), .wordWe(wordWe), .tagWe(tagWe),
    .makeDirty(makeDirty), .cleanWay(cleanWay), .flushWay(flushWay),
    .touchLru(touchLru), .useFlushSet(useFlushSet)
  );

  burstCounter count0 (
    .clk(clk), .reset(reset), .beatInc(beatInc), .beatClear(beatClear),
    .setInc(setInc), .setClear(setClear), .beat(beat), .lastBeat(lastBeat),
    .flushSet(flushSet), .lastSet(lastSet)
  );

  tagStore tags0 (
    .clk(clk), .reset(reset), .lookupSet(reqSet), .lookupTag(reqTag),
    .useFlushSet(useFlushSet), .flushSet(flushSet), .flushWay(flushWay),
    .tagWe(tagWe), .makeDirty(makeDirty), .cleanWay(cleanWay),
    .touchLru(touchLru), .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
    .victimDirty(victimDirty), .victimTag(victimTag), .dirtyW0(dirtyW0),
    .dirtyW1(dirtyW1)
  );

  dataStore data0 (
    .clk(clk), .set(activeSet), .wordSel(activeWord), .way(activeWay),
    .fillWe(fillWe), .fillData(busRData), .wordWe(wordWe),
    .byteMask(reqByteMask), .wData(reqWData), .rData(rData)
  );

endmodule

// File: dataStore.sv
`timescale 1ns/1ps

module dataStore
  import cachePkg::*;
(
  input  logic     clk,
  input  setT      set,
  input  offsetT   wordSel,
  input  logic     way,
  input  logic     fillWe,
  input  wordT     fillData,
  input  logic     wordWe,
  input  byteMaskT byteMask,
  input  wordT     wData,
  output wordT     rData
);

  // Block data as [way][set][word]
  wordT dataMem [2][numSets][wordsPerBlock];

  wordT mergedWord;

  // Masked bytes from the store, the rest kept from the array
  always_comb begin
    mergedWord = dataMem[way][set][wordSel];
    for (int b = 0; b < 4; b++) begin
      if (byteMask[b]) begin
        mergedWord[b*8 +: 8] = wData[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fillWe) begin
      dataMem[way][set][wordSel] <= fillData;
    end else if (wordWe) begin
      dataMem[way][set][wordSel] <= mergedWord;
    end
  end

  // Combinational read feeds the processor and the writeback path
  assign rData = dataMem[way][set][wordSel];

endmodule

// File: flist.f
cachePkg.sv
burstCounter.sv
tagStore.sv
dataStore.sv
cacheController.sv
dataCache.sv
cacheTb.sv

// File: run.sh
#!/bin/bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module cacheTb -o simCache \
  && ./obj_dir/simCache > sim.log 2>&1
grep -qx "Done: no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; tail -n 20 sim.log 2>/dev/null; exit 1; }

// File: tagStore.sv
`timescale 1ns/1ps

module tagStore
  import cachePkg::*;
(
  input  logic clk,
  input  logic reset,
  input  setT  lookupSet,
  input  tagT  lookupTag,
  input  logic useFlushSet,
  input  setT  flushSet,
  input  logic flushWay,
  input  logic tagWe,
  input  logic makeDirty,
  input  logic cleanWay,
  input  logic touchLru,
  output logic hit,
  output logic hitWay,
  output logic victimWay,
  output logic victimDirty,
  output tagT  victimTag,
  output logic dirtyW0,
  output logic dirtyW1
);

  tagT tagMem [2][numSets];

  // Indexed as [way][set]
  logic [1:0][numSets-1:0] validQ;
  logic [1:0][numSets-1:0] dirtyQ;

  // One bit per set naming the way to replace next
  logic [numSets-1:0] lruQ;

  logic hitW0;
  logic hitW1;

  assign hitW0  = validQ[0][lookupSet] && (tagMem[0][lookupSet] == lookupTag);
  assign hitW1  = validQ[1][lookupSet] && (tagMem[1][lookupSet] == lookupTag);
  assign hit    = hitW0 | hitW1;
  assign hitWay = hitW1;

  // Invalid ways go first, way 0 before way 1, then LRU
  always_comb begin
    if (!validQ[0][lookupSet]) begin
      victimWay = 1'b0;
    end else if (!validQ[1][lookupSet]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lruQ[lookupSet];
    end
  end

  assign victimDirty = dirtyQ[victimWay][lookupSet];
  assign victimTag   = useFlushSet ? tagMem[flushWay][flushSet] : tagMem[victimWay][lookupSet];

  assign dirtyW0 = dirtyQ[0][flushSet];
  assign dirtyW1 = dirtyQ[1][flushSet];

  always_ff @(posedge clk) begin
    if (tagWe) begin
      tagMem[victimWay][lookupSet] <= lookupTag;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validQ <= '0;
      dirtyQ <= '0;
      lruQ   <= '0;
    end else begin
      // Fill installs a clean line and points LRU at the other way
      if (tagWe) begin
        validQ[victimWay][lookupSet] <= 1'b1;
        dirtyQ[victimWay][lookupSet] <= 1'b0;
        lruQ[lookupSet]              <= ~victimWay;
      end
      if (touchLru) begin
        lruQ[lookupSet] <= ~hitWay;
      end
      if (makeDirty) begin
        dirtyQ[hitWay][lookupSet] <= 1'b1;
      end
      if (cleanWay) begin
        dirtyQ[flushWay][flushSet] <= 1'b0;
      end
    end
  end

endmodule
